/* filelist.f */
+incdir+design
design/serial_link_pkg.sv
design/sl_tx_phy.sv
design/sl_rx_phy.sv
design/serial_link.sv
sim/tb_serial_link.sv

/* Makefile */
# Verilator flow for the serial link PHY

TOP = tb_serial_link

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module serial_link
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_serial_link.sv */
////////////////////////////////////////
// Serial link testbench
// Loops the lanes back and checks each
// payload from a stimulus table
////////////////////////////////////////

`default_nettype none

`include "sl_settings.svh"

module tb_serial_link;

  localparam int NumRows     = 9;
  localparam int BeatBits    = 2 * `SL_NUM_LANES;
  // Tag plus data bits rounded up to whole beats
  localparam int ExpBeats    = (`SL_TAG_WIDTH + `SL_DATA_WIDTH + BeatBits - 1) / BeatBits;
  localparam int BusyTimeout = 2 * ExpBeats * `SL_MAX_CLK_DIV;
  localparam int RxTimeout   = 4 * `SL_MAX_CLK_DIV;
  localparam int QuietCycles = 2 * `SL_MAX_CLK_DIV;

  logic                      clk_i;
  logic                      rst_i;
  logic                      tx_valid_i;
  serial_link_pkg::tag_e     tx_tag_i;
  serial_link_pkg::data_t    tx_data_i;
  serial_link_pkg::clk_div_t clk_div_i;
  logic                      tx_busy_o;
  serial_link_pkg::lanes_t   ddr_o;
  logic                      ddr_rcv_clk_o;
  logic                      rx_valid_o;
  serial_link_pkg::tag_e     rx_tag_o;
  serial_link_pkg::data_t    rx_data_o;

  // Stimulus table with one entry per payload
  serial_link_pkg::tag_e  row_tag    [NumRows];
  serial_link_pkg::data_t row_data   [NumRows];
  int                     row_div    [NumRows];
  bit                     row_second [NumRows];

  // Payloads seen on the receive side
  serial_link_pkg::tag_e  rx_tag_q  [$];
  serial_link_pkg::data_t rx_data_q [$];

  int mismatch_cnt;
  int fail_cnt;

  // Lanes and forwarded clock looped straight back
  serial_link dut0 (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .tx_valid_i    ( tx_valid_i    ),
    .tx_tag_i      ( tx_tag_i      ),
    .tx_data_i     ( tx_data_i     ),
    .clk_div_i     ( clk_div_i     ),
    .tx_busy_o     ( tx_busy_o     ),
    .ddr_o         ( ddr_o         ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o ),
    .ddr_i         ( ddr_o         ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_o ),
    .rx_valid_o    ( rx_valid_o    ),
    .rx_tag_o      ( rx_tag_o      ),
    .rx_data_o     ( rx_data_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    if (rx_valid_o === 1'b1) begin
      rx_tag_q.push_back(rx_tag_o);
      rx_data_q.push_back(rx_data_o);
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_tag(input string name, input serial_link_pkg::tag_e got,
                           input serial_link_pkg::tag_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      mismatch_cnt++;
    end
  endtask

  task automatic check_data(input string name, input serial_link_pkg::data_t got,
                            input serial_link_pkg::data_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_lanes(input string name, input serial_link_pkg::lanes_t got,
                             input serial_link_pkg::lanes_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // Table and row sequencing
  ////////////////////////////////////////

  function automatic void set_row(input int idx, input serial_link_pkg::tag_e tag,
                                  input serial_link_pkg::data_t data, input int div,
                                  input bit second);
    row_tag[idx]    = tag;
    row_data[idx]   = data;
    row_div[idx]    = div;
    row_second[idx] = second;
  endfunction

  function automatic void build_table();
    set_row(0, serial_link_pkg::TagData, '1, 2, 1'b0);
    set_row(1, serial_link_pkg::TagCtrl, {(`SL_DATA_WIDTH/2){2'b10}}, 4, 1'b0);
    set_row(2, serial_link_pkg::TagResp, {(`SL_DATA_WIDTH/2){2'b01}}, 16, 1'b0);
    set_row(3, serial_link_pkg::TagIdle, '0, 2, 1'b0);
    set_row(4, serial_link_pkg::TagData, serial_link_pkg::data_t'($urandom()), 4, 1'b1);
    set_row(5, serial_link_pkg::TagCtrl, serial_link_pkg::data_t'($urandom()), 16, 1'b1);
    set_row(6, serial_link_pkg::TagResp, serial_link_pkg::data_t'($urandom()), 2, 1'b1);
    set_row(7, serial_link_pkg::TagIdle, serial_link_pkg::data_t'($urandom()), 16, 1'b0);
    set_row(8, serial_link_pkg::TagData, serial_link_pkg::data_t'($urandom()), 8, 1'b0);
  endfunction

  task automatic send_row(input int idx);
    int busy_cycles;
    int waited;
    @(negedge clk_i);
    tx_valid_i = 1'b1;
    tx_tag_i   = row_tag[idx];
    tx_data_i  = row_data[idx];
    clk_div_i  = serial_link_pkg::clk_div_t'(row_div[idx]);
    @(negedge clk_i);
    tx_valid_i = 1'b0;
    check_bit("tx_busy_o", tx_busy_o, 1'b1);
    // Extra strobe while busy that must never reach the line
    if (row_second[idx]) begin
      tx_valid_i = 1'b1;
      tx_tag_i   = (row_tag[idx] == serial_link_pkg::TagData) ?
                   serial_link_pkg::TagCtrl : serial_link_pkg::TagData;
      tx_data_i  = ~row_data[idx];
    end
    busy_cycles = 0;
    while (tx_busy_o === 1'b1 && busy_cycles < BusyTimeout) begin
      busy_cycles++;
      @(negedge clk_i);
      tx_valid_i = 1'b0;
    end
    tx_valid_i = 1'b0;
    if (busy_cycles >= BusyTimeout) begin
      $display("timeout at %0t: tx_busy_o stayed high for row %0d", $time, idx);
      fail_cnt++;
    end
    check_count("tx_busy_o cycles", busy_cycles, ExpBeats * row_div[idx]);

    // Receive strobe may already have come while busy was high
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (rx_tag_q.size() == 0 && waited < RxTimeout);
    if (rx_tag_q.size() == 0) begin
      $display("timeout at %0t: no rx_valid_o pulse for row %0d", $time, idx);
      fail_cnt++;
    end

    repeat (QuietCycles) begin
      @(negedge clk_i);
      check_bit("tx_busy_o", tx_busy_o, 1'b0);
    end
    @(posedge clk_i);
    check_count("rx_valid_o pulses", rx_tag_q.size(), 1);
    if (rx_tag_q.size() > 0) begin
      check_tag("rx_tag_o", rx_tag_q[0], row_tag[idx]);
      check_data("rx_data_o", rx_data_q[0], row_data[idx]);
    end
    rx_tag_q.delete();
    rx_data_q.delete();
  endtask

  initial begin
    rst_i        = 1'b1;
    tx_valid_i   = 1'b0;
    tx_tag_i     = serial_link_pkg::TagIdle;
    tx_data_i    = '0;
    clk_div_i    = serial_link_pkg::clk_div_t'(2);
    mismatch_cnt = 0;
    fail_cnt     = 0;
    void'($urandom(32'hec1));
    build_table();

    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    // Quiet line straight out of reset
    check_bit("tx_busy_o", tx_busy_o, 1'b0);
    check_bit("rx_valid_o", rx_valid_o, 1'b0);
    check_lanes("ddr_o", ddr_o, '0);
    check_bit("ddr_rcv_clk_o", ddr_rcv_clk_o, 1'b0);

    for (int i = 0; i < NumRows; i++) begin
      send_row(i);
    end

    $display("tb_serial_link done: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/serial_link.sv */
////////////////////////////////////////
// Serial link PHY top
// Transmit and receive halves of one
// link channel, side by side
////////////////////////////////////////

`default_nettype none

module serial_link (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Transmit user side
  input  logic                      tx_valid_i,
  input  serial_link_pkg::tag_e     tx_tag_i,
  input  serial_link_pkg::data_t    tx_data_i,
  input  serial_link_pkg::clk_div_t clk_div_i,
  output logic                      tx_busy_o,
  // Line side
  output serial_link_pkg::lanes_t   ddr_o,
  output logic                      ddr_rcv_clk_o,
  input  serial_link_pkg::lanes_t   ddr_i,
  input  logic                      ddr_rcv_clk_i,
  // Receive user side
  output logic                      rx_valid_o,
  output serial_link_pkg::tag_e     rx_tag_o,
  output serial_link_pkg::data_t    rx_data_o
);

  ////////////////////////////////////////
  // Transmitter
  ////////////////////////////////////////

  sl_tx_phy tx0 (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .tx_valid_i    ( tx_valid_i    ),
    .tx_tag_i      ( tx_tag_i      ),
    .tx_data_i     ( tx_data_i     ),
    .clk_div_i     ( clk_div_i     ),
    .tx_busy_o     ( tx_busy_o     ),
    .ddr_o         ( ddr_o         ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o )
  );

  ////////////////////////////////////////
  // Receiver
  ////////////////////////////////////////

  sl_rx_phy rx0 (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .ddr_i         ( ddr_i         ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .rx_valid_o    ( rx_valid_o    ),
    .rx_tag_o      ( rx_tag_o      ),
    .rx_data_o     ( rx_data_o     )
  );

endmodule

`default_nettype wire

/* design/sl_rx_phy.sv */
////////////////////////////////////////
// Receive PHY
// Samples lanes around forwarded clock
// edges and rebuilds the payload
////////////////////////////////////////

`default_nettype none

module sl_rx_phy (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  serial_link_pkg::lanes_t ddr_i,
  input  logic                    ddr_rcv_clk_i,
  output logic                    rx_valid_o,
  output serial_link_pkg::tag_e   rx_tag_o,
  output serial_link_pkg::data_t  rx_data_o
);

  localparam int BeatBits    = $bits(serial_link_pkg::beat_t);
  localparam int PayloadBits = $bits(serial_link_pkg::payload_t);
  localparam serial_link_pkg::beat_cnt_t LastBeat =
    serial_link_pkg::beat_cnt_t'(serial_link_pkg::NumBeats - 1);

  logic                       clk_q;
  serial_link_pkg::lanes_t    lanes_q;
  serial_link_pkg::frame_t    frame_q;
  serial_link_pkg::frame_t    frame_d;
  serial_link_pkg::beat_cnt_t beat_q;
  serial_link_pkg::beat_t     beat;
  serial_link_pkg::payload_t  payload;
  logic                       rise;
  logic                       last;

  ////////////////////////////////////////
  // Edge detect and beat assembly
  ////////////////////////////////////////

  assign rise = ddr_rcv_clk_i && !clk_q;

  // Even half was on the lanes one cycle before the edge
  assign beat = {ddr_i, lanes_q};
  assign last = rise && (beat_q == LastBeat);

  always_comb begin
    frame_d = frame_q;
    frame_d[beat_q*BeatBits +: BeatBits] = beat;
    // Padding above the payload is dropped here
    payload = serial_link_pkg::payload_t'(frame_d[PayloadBits-1:0]);
  end

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      clk_q      <= 1'b0;
      beat_q     <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      clk_q      <= ddr_rcv_clk_i;
      rx_valid_o <= last;
      if (last) begin
        beat_q <= '0;
      end else if (rise) begin
        beat_q <= beat_q + serial_link_pkg::beat_cnt_t'(1);
      end
    end
  end

  // Lane history, frame store and output payload
  always_ff @(posedge clk_i) begin
    lanes_q <= ddr_i;
    if (rise) begin
      frame_q <= frame_d;
    end
    if (last) begin
      rx_tag_o  <= payload.tag;
      rx_data_o <= payload.data;
    end
  end

endmodule

`default_nettype wire

/* design/sl_tx_phy.sv */
////////////////////////////////////////
// Transmit PHY
// Serializes a payload into DDR lane
// beats with a divided forwarded clock
////////////////////////////////////////

`default_nettype none

`include "sl_settings.svh"

module sl_tx_phy (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      tx_valid_i,
  input  serial_link_pkg::tag_e     tx_tag_i,
  input  serial_link_pkg::data_t    tx_data_i,
  input  serial_link_pkg::clk_div_t clk_div_i,
  output logic                      tx_busy_o,
  output serial_link_pkg::lanes_t   ddr_o,
  output logic                      ddr_rcv_clk_o
);

  localparam int BeatBits = $bits(serial_link_pkg::beat_t);
  localparam serial_link_pkg::beat_cnt_t LastBeat =
    serial_link_pkg::beat_cnt_t'(serial_link_pkg::NumBeats - 1);

  typedef enum logic {
    TxIdle,
    TxSend
  } tx_state_e;

  tx_state_e                  state_q;
  serial_link_pkg::frame_t    frame_q;
  serial_link_pkg::clk_div_t  div_q;
  serial_link_pkg::clk_div_t  phase_q;
  serial_link_pkg::beat_cnt_t beat_q;
  serial_link_pkg::payload_t  payload;
  serial_link_pkg::beat_t     cur_beat;
  logic                       accept;
  logic                       beat_end;
  logic                       high_half;

  always_comb begin
    payload.tag  = tx_tag_i;
    payload.data = tx_data_i;
  end

  // Strobes are only taken while idle
  assign accept   = tx_valid_i && (state_q == TxIdle);
  assign beat_end = (phase_q == div_q - serial_link_pkg::clk_div_t'(1));

  ////////////////////////////////////////
  // Beat and phase sequencing
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= TxIdle;
      phase_q <= '0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        TxIdle: begin
          if (accept) begin
            state_q <= TxSend;
          end
        end
        TxSend: begin
          if (beat_end) begin
            phase_q <= '0;
            if (beat_q == LastBeat) begin
              state_q <= TxIdle;
              beat_q  <= '0;
            end else begin
              beat_q <= beat_q + serial_link_pkg::beat_cnt_t'(1);
            end
          end else begin
            phase_q <= phase_q + serial_link_pkg::clk_div_t'(1);
          end
        end
        default: state_q <= TxIdle;
      endcase
    end
  end

  // Frame shifts down so the current beat is always at the bottom
  always_ff @(posedge clk_i) begin
    if (accept) begin
      frame_q <= serial_link_pkg::frame_t'(payload);
      div_q   <= clk_div_i;
    end else if ((state_q == TxSend) && beat_end) begin
      frame_q <= frame_q >> BeatBits;
    end
  end

  ////////////////////////////////////////
  // Line outputs
  ////////////////////////////////////////

  assign tx_busy_o = (state_q == TxSend);
  assign cur_beat  = frame_q[BeatBits-1:0];
  // Second half of each beat period drives the clock high
  assign high_half = (phase_q >= (div_q >> 1));

  assign ddr_rcv_clk_o = tx_busy_o && high_half;
  assign ddr_o = !tx_busy_o ? '0 :
                 high_half ? cur_beat[2*`SL_NUM_LANES-1:`SL_NUM_LANES] :
                             cur_beat[`SL_NUM_LANES-1:0];

endmodule

`default_nettype wire

/* design/serial_link_pkg.sv */
////////////////////////////////////////
// Serial link package
// Vector types, header tags and beat
// framing shared by the PHY blocks
////////////////////////////////////////

`default_nettype none

`include "sl_settings.svh"

package serial_link_pkg;

  typedef logic [`SL_NUM_LANES-1:0] lanes_t;

  // Two bits per lane with one per half-period
  typedef logic [2*`SL_NUM_LANES-1:0] beat_t;

  typedef logic [`SL_DATA_WIDTH-1:0] data_t;

  typedef enum logic [`SL_TAG_WIDTH-1:0] {
    TagIdle,
    TagData,
    TagCtrl,
    TagResp
  } tag_e;

  // Tag sits above the data word
  typedef struct packed {
    tag_e  tag;
    data_t data;
  } payload_t;

  localparam int NumBeats = ($bits(payload_t) + $bits(beat_t) - 1) / $bits(beat_t);

  // Payload zero-padded up to whole beats
  typedef logic [NumBeats*$bits(beat_t)-1:0] frame_t;

  typedef logic [$clog2(NumBeats+1)-1:0] beat_cnt_t;
  typedef logic [$clog2(`SL_MAX_CLK_DIV+1)-1:0] clk_div_t;

endpackage

`default_nettype wire

/* design/sl_settings.svh */
////////////////////////////////////////
// Serial link settings
// Lane count, word widths and the clock
// divider limit for the link PHY
////////////////////////////////////////

`ifndef SL_SETTINGS_SVH
`define SL_SETTINGS_SVH

// Physical lanes per direction
`define SL_NUM_LANES 4

// User data word and header tag widths
`define SL_DATA_WIDTH 32
`define SL_TAG_WIDTH 2

// Largest even forwarded clock divider
`define SL_MAX_CLK_DIV 16

`endif
